// ==== hw/rx_emu_defines.svh ====
`ifndef RX_EMU_DEFINES_SVH
`define RX_EMU_DEFINES_SVH

// interleave geometry
`define RX_NTI 16
`define RX_NGRP 4           // slices sharing one PI code

// tap table shape
`define RX_NTAPS 8
`define RX_NBANKS 4

// datapath widths
`define RX_NADC 8           // magnitude bits per slice
`define RX_ACC_W 12         // 8 products of +-128 fit with margin

// register map, byte addresses
`define RX_ADDR_PI 8'h20
`define RX_ADDR_TAP_TOP 8'h1C

`endif

// ==== hw/rx_emu_pkg.sv ====
`default_nettype none

`include "rx_emu_defines.svh"

package rx_emu_pkg;

    // one signed pulse-response sample
    typedef logic signed [7:0] tap_t;

    typedef tap_t [`RX_NTAPS-1:0] tap_bank_t;

    // indexed by bank, driven from the register block
    typedef tap_bank_t [`RX_NBANKS-1:0] tap_table_t;

    // phase interpolator code
    // only the bank field affects the model, fine is kept for readback
    typedef struct packed {
        logic [1:0] bank;
        logic [5:0] fine;
    } pi_code_t;

    typedef pi_code_t [`RX_NTI/`RX_NGRP-1:0] pi_codes_t;

    // one 32-bit register word
    // tap addresses use the taps view, the PI address the pi view
    typedef union packed {
        tap_t [3:0]     taps;
        pi_code_t [3:0] pi;
    } csr_word_u;

    typedef logic [7:0] chunk_t;   // slice of the bit history

endpackage

`default_nettype wire

// ==== hw/slice_ctl_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// broadcast from the frame sequencer to every ADC slice
interface slice_ctl_if;

    rx_emu_pkg::chunk_t chunk;    // 8 history bits for this cycle
    logic [1:0] chunk_idx;        // which history byte is on chunk
    logic acc_clear;              // first chunk of a new frame
    logic out_load;               // slices capture sign and magnitude

    modport seq (
        output chunk,
        output chunk_idx,
        output acc_clear,
        output out_load
    );

    modport slice (
        input chunk,
        input chunk_idx,
        input acc_clear,
        input out_load
    );

endinterface

`default_nettype wire

// ==== hw/rx_adc_slice.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rx_emu_defines.svh"

module rx_adc_slice (
    input  wire logic                   emu_clk,
    input  wire logic                   emu_rst,
    slice_ctl_if.slice                  ctl,
    input  wire logic [3:0]             slice_idx_i,   // position in the interleave
    input  wire rx_emu_pkg::tap_bank_t  taps_i,        // bank picked by the group PI code
    output logic                        sign_o,
    output logic [`RX_NADC-1:0]         mag_o
);

    logic signed [`RX_ACC_W-1:0] step;     // sum over window bits in this chunk
    logic signed [`RX_ACC_W-1:0] acc;
    logic [`RX_ACC_W-1:0] abs_val;
    logic [`RX_NADC-1:0] mag_sat;

    // window bit k sits at history[16 + slice_idx - k]
    // history byte 3-c is on the chunk when chunk_idx is c
    always_comb begin : chunk_sum
        logic [4:0] pos;
        logic signed [`RX_ACC_W-1:0] tap_ext;

        step = '0;
        for (int k = 0; k < `RX_NTAPS; k++) begin
            pos = 5'd16 + {1'b0, slice_idx_i} - 5'(k);
            tap_ext = $signed(taps_i[k]);
            if (pos[4:3] == ~ctl.chunk_idx) begin
                if (ctl.chunk[pos[2:0]]) begin
                    step = step + tap_ext;    // bit 1 counts as +1
                end else begin
                    step = step - tap_ext;    // bit 0 counts as -1
                end
            end
        end
    end

    // running sum, only meaningful up to the load cycle
    always_ff @(posedge emu_clk) begin
        if (emu_rst) begin
            acc <= '0;
        end else if (ctl.acc_clear) begin
            acc <= step;
        end else begin
            acc <= acc + step;
        end
    end

    assign abs_val = acc[`RX_ACC_W-1] ? -acc : acc;

    // clip to full scale of the ADC
    assign mag_sat = (|abs_val[`RX_ACC_W-1:`RX_NADC]) ? '1 : abs_val[`RX_NADC-1:0];

    always_ff @(posedge emu_clk) begin
        if (emu_rst) begin
            sign_o <= 1'b0;
            mag_o  <= '0;
        end else if (ctl.out_load) begin
            sign_o <= acc[`RX_ACC_W-1];
            mag_o  <= mag_sat;
        end
    end

endmodule

`default_nettype wire

// ==== hw/rx_analog_core.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rx_emu_defines.svh"

module rx_analog_core (
    input  wire logic                    emu_clk,
    input  wire logic                    emu_rst,
    input  wire logic [15:0]             rx_bits_i,
    input  wire rx_emu_pkg::tap_table_t  tap_table_i,
    input  wire rx_emu_pkg::pi_codes_t   pi_codes_i,    // active codes, stable over a frame
    output logic                         rx_ready_o,
    output logic                         frame_last_o,
    output logic                         adc_valid_o,
    output logic [`RX_NTI-1:0]           adc_sign_o,
    output logic [`RX_NTI*`RX_NADC-1:0]  adc_mag_o,
    output logic                         adc_clk_o
);

    logic [2:0] frame_cnt;
    logic [31:0] history;     // newest word in the upper half
    logic last_cnt;

    slice_ctl_if slice_ctl ();

    // six-cycle frame
    always_ff @(posedge emu_clk) begin
        if (emu_rst) begin
            frame_cnt <= '0;
        end else if (last_cnt) begin
            frame_cnt <= '0;
        end else begin
            frame_cnt <= frame_cnt + 3'd1;
        end
    end

    assign last_cnt = (frame_cnt == 3'd5);

    // new word enters on the edge that closes the frame
    always_ff @(posedge emu_clk) begin
        if (emu_rst) begin
            history <= '0;
        end else if (last_cnt) begin
            history <= {rx_bits_i, history[31:16]};
        end
    end

    // chunk c carries history[31-8c : 24-8c] during counts 0 to 3
    assign slice_ctl.chunk_idx = (frame_cnt < 3'd4) ? frame_cnt[1:0] : 2'd0;
    assign slice_ctl.chunk     = history[{~slice_ctl.chunk_idx, 3'b000} +: 8];
    assign slice_ctl.acc_clear = (frame_cnt == 3'd0);
    assign slice_ctl.out_load  = (frame_cnt == 3'd4);

    assign rx_ready_o   = last_cnt;
    assign frame_last_o = last_cnt;
    assign adc_valid_o  = last_cnt;    // outputs were loaded one cycle earlier

    // sampling clock low while the slices convert
    assign adc_clk_o = !((frame_cnt >= 3'd2) && (frame_cnt <= 3'd4));

    for (genvar i = 0; i < `RX_NTI; i++) begin : g_slice
        rx_emu_pkg::tap_bank_t slice_taps;

        // group PI code picks the bank
        assign slice_taps = tap_table_i[pi_codes_i[i / `RX_NGRP].bank];

        rx_adc_slice rx_adc_slice_i (
            .emu_clk     (emu_clk),
            .emu_rst     (emu_rst),
            .ctl         (slice_ctl),
            .slice_idx_i (4'(i)),
            .taps_i      (slice_taps),
            .sign_o      (adc_sign_o[i]),
            .mag_o       (adc_mag_o[i*`RX_NADC +: `RX_NADC])
        );
    end

endmodule

`default_nettype wire

// ==== hw/rx_tap_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rx_emu_defines.svh"

module rx_tap_regs (
    input  wire logic               emu_clk,
    input  wire logic               emu_rst,
    input  wire logic [7:0]         axi_awaddr_i,
    input  wire logic               axi_awvalid_i,
    output logic                    axi_awready_o,
    input  wire logic [31:0]        axi_wdata_i,
    input  wire logic [3:0]         axi_wstrb_i,
    input  wire logic               axi_wvalid_i,
    output logic                    axi_wready_o,
    output logic [1:0]              axi_bresp_o,
    output logic                    axi_bvalid_o,
    input  wire logic               axi_bready_i,
    input  wire logic [7:0]         axi_araddr_i,
    input  wire logic               axi_arvalid_i,
    output logic                    axi_arready_o,
    output logic [31:0]             axi_rdata_o,
    output logic [1:0]              axi_rresp_o,
    output logic                    axi_rvalid_o,
    input  wire logic               axi_rready_i,
    input  wire logic               frame_last_i,   // last cycle of the current frame
    output rx_emu_pkg::tap_table_t  tap_table_o,
    output rx_emu_pkg::pi_codes_t   pi_codes_o      // active copy seen by the core
);

    logic wr_fire;
    logic rd_fire;
    logic wr_is_tap;
    logic wr_is_pi;
    logic rd_is_tap;
    logic rd_is_pi;
    rx_emu_pkg::csr_word_u wr_word;
    rx_emu_pkg::csr_word_u rd_word;
    rx_emu_pkg::pi_codes_t pi_shadow;   // written by software, copied at frame end

    // AW and W taken together, one write in flight
    assign wr_fire       = axi_awvalid_i && axi_wvalid_i && !axi_bvalid_o;
    assign axi_awready_o = wr_fire;
    assign axi_wready_o  = wr_fire;
    assign rd_fire       = axi_arvalid_i && !axi_rvalid_o;
    assign axi_arready_o = rd_fire;

    assign axi_bresp_o = 2'b00;   // always OKAY
    assign axi_rresp_o = 2'b00;

    // word decode, bank in addr[4:3] and half-bank in addr[2]
    assign wr_is_tap = (axi_awaddr_i[7:2] <= (`RX_ADDR_TAP_TOP >> 2));
    assign wr_is_pi  = (axi_awaddr_i[7:2] == (`RX_ADDR_PI >> 2));
    assign rd_is_tap = (axi_araddr_i[7:2] <= (`RX_ADDR_TAP_TOP >> 2));
    assign rd_is_pi  = (axi_araddr_i[7:2] == (`RX_ADDR_PI >> 2));

    assign wr_word = axi_wdata_i;

    always_ff @(posedge emu_clk) begin
        if (emu_rst) begin
            tap_table_o <= '0;
            pi_shadow   <= '0;
        end else if (wr_fire) begin
            for (int n = 0; n < 4; n++) begin
                if (axi_wstrb_i[n] && wr_is_tap) begin
                    tap_table_o[axi_awaddr_i[4:3]][{axi_awaddr_i[2], 2'(n)}] <= wr_word.taps[n];
                end else if (axi_wstrb_i[n] && wr_is_pi) begin
                    pi_shadow[n] <= wr_word.pi[n];
                end
            end
        end
    end

    // shadow goes live in the first cycle of the next frame
    always_ff @(posedge emu_clk) begin
        if (emu_rst) begin
            pi_codes_o <= '0;
        end else if (frame_last_i) begin
            pi_codes_o <= pi_shadow;
        end
    end

    always_ff @(posedge emu_clk) begin
        if (emu_rst) begin
            axi_bvalid_o <= 1'b0;
        end else if (wr_fire) begin
            axi_bvalid_o <= 1'b1;
        end else if (axi_bready_i) begin
            axi_bvalid_o <= 1'b0;
        end
    end

    // unmapped addresses read as zero
    always_comb begin
        rd_word = '0;
        if (rd_is_tap) begin
            for (int n = 0; n < 4; n++) begin
                rd_word.taps[n] = tap_table_o[axi_araddr_i[4:3]][{axi_araddr_i[2], 2'(n)}];
            end
        end else if (rd_is_pi) begin
            rd_word.pi = pi_shadow;   // readback shows the staged codes
        end
    end

    always_ff @(posedge emu_clk) begin
        if (emu_rst) begin
            axi_rvalid_o <= 1'b0;
            axi_rdata_o  <= '0;
        end else if (rd_fire) begin
            axi_rvalid_o <= 1'b1;
            axi_rdata_o  <= rd_word;
        end else if (axi_rready_i) begin
            axi_rvalid_o <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== hw/rx_emu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rx_emu_defines.svh"

module rx_emu_top (
    input  wire logic                    emu_clk,
    input  wire logic                    emu_rst,
    // configuration port
    input  wire logic [7:0]              axi_awaddr_i,
    input  wire logic                    axi_awvalid_i,
    output logic                         axi_awready_o,
    input  wire logic [31:0]             axi_wdata_i,
    input  wire logic [3:0]              axi_wstrb_i,
    input  wire logic                    axi_wvalid_i,
    output logic                         axi_wready_o,
    output logic [1:0]                   axi_bresp_o,
    output logic                         axi_bvalid_o,
    input  wire logic                    axi_bready_i,
    input  wire logic [7:0]              axi_araddr_i,
    input  wire logic                    axi_arvalid_i,
    output logic                         axi_arready_o,
    output logic [31:0]                  axi_rdata_o,
    output logic [1:0]                   axi_rresp_o,
    output logic                         axi_rvalid_o,
    input  wire logic                    axi_rready_i,
    // line bits in, samples out
    input  wire logic [15:0]             rx_bits_i,
    output logic                         rx_ready_o,
    output logic                         adc_valid_o,
    output logic [`RX_NTI-1:0]           adc_sign_o,
    output logic [`RX_NTI*`RX_NADC-1:0]  adc_mag_o,      // slice i in bits 8i+7:8i
    output logic                         adc_clk_o
);

    rx_emu_pkg::tap_table_t tap_table;
    rx_emu_pkg::pi_codes_t pi_codes;
    logic frame_last;

    rx_tap_regs rx_tap_regs_i (
        .emu_clk       (emu_clk),
        .emu_rst       (emu_rst),
        .axi_awaddr_i  (axi_awaddr_i),
        .axi_awvalid_i (axi_awvalid_i),
        .axi_awready_o (axi_awready_o),
        .axi_wdata_i   (axi_wdata_i),
        .axi_wstrb_i   (axi_wstrb_i),
        .axi_wvalid_i  (axi_wvalid_i),
        .axi_wready_o  (axi_wready_o),
        .axi_bresp_o   (axi_bresp_o),
        .axi_bvalid_o  (axi_bvalid_o),
        .axi_bready_i  (axi_bready_i),
        .axi_araddr_i  (axi_araddr_i),
        .axi_arvalid_i (axi_arvalid_i),
        .axi_arready_o (axi_arready_o),
        .axi_rdata_o   (axi_rdata_o),
        .axi_rresp_o   (axi_rresp_o),
        .axi_rvalid_o  (axi_rvalid_o),
        .axi_rready_i  (axi_rready_i),
        .frame_last_i  (frame_last),
        .tap_table_o   (tap_table),
        .pi_codes_o    (pi_codes)
    );

    rx_analog_core rx_analog_core_i (
        .emu_clk      (emu_clk),
        .emu_rst      (emu_rst),
        .rx_bits_i    (rx_bits_i),
        .tap_table_i  (tap_table),
        .pi_codes_i   (pi_codes),
        .rx_ready_o   (rx_ready_o),
        .frame_last_o (frame_last),
        .adc_valid_o  (adc_valid_o),
        .adc_sign_o   (adc_sign_o),
        .adc_mag_o    (adc_mag_o),
        .adc_clk_o    (adc_clk_o)
    );

endmodule

`default_nettype wire

// ==== tests/rx_emu_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rx_emu_defines.svh"

module rx_emu_tb;

    localparam int NROWS = 5;
    localparam int MAXW = 24;
    localparam int SKIP = 3;        // frames until history and config settle
    localparam int TMO = 64;        // cycles allowed for any single wait
    localparam logic [15:0] FIXED_WORDS [8] = '{16'ha5c3, 16'h0f0f, 16'h1234, 16'hffff,
                                               16'h0000, 16'h8001, 16'h7ffe, 16'hc3a5};

    logic emu_clk = 1'b0;
    logic emu_rst;
    logic [7:0] axi_awaddr;
    logic axi_awvalid;
    logic axi_awready;
    logic [31:0] axi_wdata;
    logic [3:0] axi_wstrb;
    logic axi_wvalid;
    logic axi_wready;
    logic [1:0] axi_bresp;
    logic axi_bvalid;
    logic axi_bready;
    logic [7:0] axi_araddr;
    logic axi_arvalid;
    logic axi_arready;
    logic [31:0] axi_rdata;
    logic [1:0] axi_rresp;
    logic axi_rvalid;
    logic axi_rready;
    logic [15:0] rx_bits;
    logic rx_ready;
    logic adc_valid;
    logic [`RX_NTI-1:0] adc_sign;
    logic [`RX_NTI*`RX_NADC-1:0] adc_mag;
    logic adc_clk;

    // stimulus table with one entry per row
    string row_name [NROWS];
    rx_emu_pkg::tap_table_t row_taps [NROWS];
    rx_emu_pkg::pi_codes_t row_pi [NROWS];
    logic [15:0] row_words [NROWS][MAXW];
    int row_nw [NROWS];
    int row_exp_mag [NROWS];     // -1 when only the model applies
    int row_exp_sign [NROWS];

    logic [31:0] hist_m;         // model of the DUT bit history
    logic [15:0] pending;        // word on rx_bits that the DUT takes at the next ready

    always #2 emu_clk = ~emu_clk;

    rx_emu_top rx_emu_top_i (
        .emu_clk       (emu_clk),
        .emu_rst       (emu_rst),
        .axi_awaddr_i  (axi_awaddr),
        .axi_awvalid_i (axi_awvalid),
        .axi_awready_o (axi_awready),
        .axi_wdata_i   (axi_wdata),
        .axi_wstrb_i   (axi_wstrb),
        .axi_wvalid_i  (axi_wvalid),
        .axi_wready_o  (axi_wready),
        .axi_bresp_o   (axi_bresp),
        .axi_bvalid_o  (axi_bvalid),
        .axi_bready_i  (axi_bready),
        .axi_araddr_i  (axi_araddr),
        .axi_arvalid_i (axi_arvalid),
        .axi_arready_o (axi_arready),
        .axi_rdata_o   (axi_rdata),
        .axi_rresp_o   (axi_rresp),
        .axi_rvalid_o  (axi_rvalid),
        .axi_rready_i  (axi_rready),
        .rx_bits_i     (rx_bits),
        .rx_ready_o    (rx_ready),
        .adc_valid_o   (adc_valid),
        .adc_sign_o    (adc_sign),
        .adc_mag_o     (adc_mag),
        .adc_clk_o     (adc_clk)
    );

    task automatic abort_run();
        $display("Test failed");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic report_timeout(input string what);
        $display("timeout: %s never came", what);
        abort_run();
    endtask

    task automatic check_mag(input string name, input logic [`RX_NADC-1:0] exp_v,
                             input logic [`RX_NADC-1:0] act_v);
        if (exp_v !== act_v) begin
            $display("[FAIL] %s: magnitude expected %0d, actual %0d", name, exp_v, act_v);
            abort_run();
        end
    endtask

    task automatic check_sign(input string name, input logic exp_v, input logic act_v);
        if (exp_v !== act_v) begin
            $display("[FAIL] %s: sign expected %b, actual %b", name, exp_v, act_v);
            abort_run();
        end
    endtask

    task automatic check_word(input string name, input rx_emu_pkg::csr_word_u exp_v,
                              input rx_emu_pkg::csr_word_u act_v);
        if (exp_v !== act_v) begin
            $display("[FAIL] %s: word expected %h, actual %h", name, exp_v, act_v);
            abort_run();
        end
    endtask

    task automatic check_resp(input string name, input logic [1:0] exp_v,
                              input logic [1:0] act_v);
        if (exp_v !== act_v) begin
            $display("[FAIL] %s: response expected %b, actual %b", name, exp_v, act_v);
            abort_run();
        end
    endtask

    task automatic axi_write(input logic [7:0] addr, input logic [31:0] data,
                             output logic [1:0] resp);
        int n;
        @(posedge emu_clk);
        axi_awaddr  <= addr;
        axi_awvalid <= 1'b1;
        axi_wdata   <= data;
        axi_wstrb   <= 4'hf;
        axi_wvalid  <= 1'b1;
        n = 0;
        do begin
            @(negedge emu_clk);
            n++;
            if (n > TMO) report_timeout("awready and wready");
        end while (!(axi_awready && axi_wready));
        @(posedge emu_clk);          // handshake edge
        axi_awvalid <= 1'b0;
        axi_wvalid  <= 1'b0;
        n = 0;
        do begin
            @(negedge emu_clk);
            n++;
            if (n > TMO) report_timeout("bvalid");
        end while (!axi_bvalid);
        resp = axi_bresp;
    endtask

    task automatic axi_read(input logic [7:0] addr, output logic [31:0] data,
                            output logic [1:0] resp);
        int n;
        @(posedge emu_clk);
        axi_araddr  <= addr;
        axi_arvalid <= 1'b1;
        n = 0;
        do begin
            @(negedge emu_clk);
            n++;
            if (n > TMO) report_timeout("arready");
        end while (!axi_arready);
        @(posedge emu_clk);
        axi_arvalid <= 1'b0;
        n = 0;
        do begin
            @(negedge emu_clk);
            n++;
            if (n > TMO) report_timeout("rvalid");
        end while (!axi_rvalid);
        data = axi_rdata;
        resp = axi_rresp;
    endtask

    task automatic read_expect(input string name, input logic [7:0] addr,
                               input rx_emu_pkg::csr_word_u exp_v);
        logic [31:0] data;
        logic [1:0] resp;
        axi_read(addr, data, resp);
        check_resp(name, 2'b00, resp);
        check_word(name, exp_v, data);
    endtask

    task automatic write_read(input string name, input logic [7:0] addr,
                              input rx_emu_pkg::csr_word_u wr,
                              input rx_emu_pkg::csr_word_u exp_v);
        logic [1:0] resp;
        axi_write(addr, wr, resp);
        check_resp(name, 2'b00, resp);
        read_expect(name, addr, exp_v);
    endtask

    // tap k weighs history bit 16+idx-k as +1 or -1
    function automatic int slice_sum(input logic [31:0] h, input rx_emu_pkg::tap_bank_t bank,
                                     input int idx);
        int s;
        s = 0;
        for (int k = 0; k < `RX_NTAPS; k++) begin
            if (h[16 + idx - k]) s = s + int'(bank[k]);
            else s = s - int'(bank[k]);
        end
        return s;
    endfunction

    task automatic write_config(input int r);
        rx_emu_pkg::csr_word_u wr;
        for (int b = 0; b < `RX_NBANKS; b++) begin
            for (int w = 0; w < 2; w++) begin
                for (int n = 0; n < 4; n++) wr.taps[n] = row_taps[r][b][4 * w + n];
                write_read(row_name[r], 8'(8 * b + 4 * w), wr, wr);
            end
        end
        wr.pi = row_pi[r];
        write_read(row_name[r], `RX_ADDR_PI, wr, wr);
    endtask

    // waits for one ready pulse, checks it, then hands over the next word
    task automatic send_frame(input int r, input int w_idx);
        int n;
        int s;
        int abs_s;
        int clk_low;
        logic [7:0] exp_mag;
        rx_emu_pkg::pi_code_t code;
        n = 0;
        clk_low = 0;
        do begin
            @(negedge emu_clk);
            n++;
            if (n > TMO) report_timeout("rx_ready_o");
            if (!adc_clk) clk_low++;
        end while (!rx_ready);
        if (w_idx >= SKIP) begin
            if (!adc_valid || !adc_clk) begin
                $display("%s: adc_valid_o or adc_clk_o was low at rx_ready_o", row_name[r]);
                abort_run();
            end
            // sampling clock is low for counts 2 to 4
            if (clk_low != 3) begin
                $display("[FAIL] %s: adc_clk_o low cycles expected 3, actual %0d",
                         row_name[r], clk_low);
                abort_run();
            end
            for (int i = 0; i < `RX_NTI; i++) begin
                code = row_pi[r][i / `RX_NGRP];
                s = slice_sum(hist_m, row_taps[r][code.bank], i);
                abs_s = (s < 0) ? -s : s;
                exp_mag = (abs_s > 255) ? 8'hff : 8'(abs_s);
                check_mag(row_name[r], exp_mag, adc_mag[i*`RX_NADC +: `RX_NADC]);
                check_sign(row_name[r], s < 0, adc_sign[i]);
                if (row_exp_mag[r] >= 0)
                    check_mag(row_name[r], 8'(row_exp_mag[r]), adc_mag[i*`RX_NADC +: `RX_NADC]);
                if (row_exp_sign[r] >= 0)
                    check_sign(row_name[r], row_exp_sign[r] != 0, adc_sign[i]);
            end
        end
        @(posedge emu_clk);          // DUT takes the pending word here
        rx_bits <= row_words[r][w_idx];
        hist_m = {pending, hist_m[31:16]};
        pending = row_words[r][w_idx];
    endtask

    task automatic load_table();
        for (int r = 0; r < NROWS; r++) begin
            row_taps[r] = '0;
            row_pi[r] = '0;
            row_exp_mag[r] = -1;
            row_exp_sign[r] = -1;
        end
        row_name[0] = "identity";
        row_taps[0][0][0] = 8'sd1;
        row_exp_mag[0] = 1;
        row_nw[0] = 8;
        row_name[1] = "random_taps";
        row_pi[1] = $urandom;
        row_nw[1] = SKIP + 20;
        row_name[2] = "saturate_pos";
        row_exp_mag[2] = 255;
        row_exp_sign[2] = 0;
        row_nw[2] = 6;
        row_name[3] = "saturate_neg";
        row_exp_mag[3] = 255;
        row_exp_sign[3] = 1;
        row_nw[3] = 6;
        row_name[4] = "pi_groups";
        row_nw[4] = 8;
        for (int g = 0; g < `RX_NTI / `RX_NGRP; g++) begin
            row_pi[4][g] = '{bank: 2'(3 - g), fine: 6'(5 * g + 1)};
        end
        for (int b = 0; b < `RX_NBANKS; b++) begin
            for (int k = 0; k < `RX_NTAPS; k++) begin
                row_taps[1][b][k] = 8'($urandom);
                row_taps[2][b][k] = 8'sd127;
                row_taps[3][b][k] = -8'sd128;
                row_taps[4][b][k] = 8'((b + 1) * (k - 3));
            end
        end
        for (int i = 0; i < MAXW; i++) begin
            row_words[0][i] = FIXED_WORDS[i % 8];
            row_words[1][i] = 16'($urandom);
            row_words[2][i] = 16'hffff;
            row_words[3][i] = 16'hffff;
            row_words[4][i] = FIXED_WORDS[i % 8] ^ 16'h5a5a;
        end
    endtask

    initial begin
        void'($urandom(32'h99ac_cb56));
        emu_rst = 1'b1;
        axi_awaddr = '0;
        axi_awvalid = 1'b0;
        axi_wdata = '0;
        axi_wstrb = '0;
        axi_wvalid = 1'b0;
        axi_bready = 1'b1;
        axi_araddr = '0;
        axi_arvalid = 1'b0;
        axi_rready = 1'b1;
        rx_bits = '0;
        hist_m = '0;
        pending = '0;
        load_table();
        repeat (8) @(posedge emu_clk);
        emu_rst <= 1'b0;
        @(negedge emu_clk);
        if (rx_ready || adc_valid) begin
            $display("rx_ready_o or adc_valid_o was high right after reset");
            abort_run();
        end
        for (int i = 0; i < `RX_NTI; i++) begin
            check_mag("reset", '0, adc_mag[i*`RX_NADC +: `RX_NADC]);
            check_sign("reset", 1'b0, adc_sign[i]);
        end
        for (int a = 0; a <= 32'(`RX_ADDR_PI); a += 4) read_expect("reset", 8'(a), '0);
        write_read("unmapped", 8'h24, 32'hdead_beef, '0);
        write_read("unmapped", 8'ha0, 32'h1234_5678, '0);
        read_expect("unmapped", 8'h00, '0);    // 0xa0 must not alias onto bank 0
        read_expect("unmapped", `RX_ADDR_PI, '0);    // 0x24 must not reach the PI word
        for (int r = 0; r < NROWS; r++) begin
            write_config(r);
            for (int i = 0; i < row_nw[r]; i++) send_frame(r, i);
        end
        $display("Test passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== rx_emu.f ====
+incdir+hw
hw/rx_emu_pkg.sv
hw/slice_ctl_if.sv
hw/rx_adc_slice.sv
hw/rx_analog_core.sv
hw/rx_tap_regs.sv
hw/rx_emu_top.sv
tests/rx_emu_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the rx_emu testbench with Verilator, run it, and check the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing -Wno-fatal --top-module rx_emu_tb \
    -f rx_emu.f -o rx_emu_sim --Mdir obj_dir > build.log 2>&1 \
    && ./obj_dir/rx_emu_sim > sim.log 2>&1 \
    || echo "build or simulation reported an error, see build.log and sim.log"

touch sim.log
grep -qx "Test passed" sim.log \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }
exit 0
